// ==== compile.f ====
+incdir+rtl
rtl/video_stream_pkg.sv
rtl/window_pkg.sv
rtl/video_pos_counter.sv
rtl/window_cfg_latch.sv
rtl/axis_window.sv
rtl/video_window_top.sv
tests/video_window_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video window testbench with Verilator.
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f \
	--top-module video_window_tb \
	-Mdir "$BUILD_DIR/obj_dir" \
	-o video_window_sim

# Pass or fail comes from the log.
"$BUILD_DIR/obj_dir/video_window_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// ==== tests/video_window_tb.sv ====
`timescale 1ns/1ns
`include "video_consts.svh"

module video_window_tb;

	localparam int CLK_HALF       = 20;
	localparam int DRIVE_DELAY    = 2;
	localparam int ROWS           = 10;
	localparam int COLS           = 10;
	localparam int FRAMES         = 6;
	localparam int TIMEOUT_CYCLES = FRAMES * ROWS * COLS * 4 + 1600;   // 4000 cycles.

	logic                         clk = 1'b0;
	logic                         resetn;
	video_stream_pkg::axis_beat_t s_beat;
	logic                         s_valid;
	logic                         s_ready;
	video_stream_pkg::axis_beat_t m_beat;
	logic                         m_valid;
	logic                         m_ready;
	window_pkg::win_cfg_t         win_cfg;
	window_pkg::img_size_t        img_size;

	logic [31:0] lfsr_state = 32'hb094;
	int          cycles = 0;
	logic        kept_seen = 1'b0;   // A kept beat has entered the DUT.

	// Expected output beats in order, filled one frame ahead.
	video_stream_pkg::axis_beat_t exp_mem [0:FRAMES*ROWS*COLS-1];
	int                           exp_wr = 0;
	int                           exp_rd = 0;
	video_stream_pkg::axis_beat_t exp_head;
	logic                         exp_avail;

	int exp_counts [0:FRAMES-1];
	int exp_frames = 0;
	int obs_counts [0:FRAMES-1];
	int obs_frames = 0;

	int data_errors = 0;
	int user_errors = 0;
	int last_errors = 0;
	int count_errors = 0;
	int protocol_errors = 0;

	always #CLK_HALF clk = ~clk;

	video_window_top video_window_top_inst (
		.clk      (clk),
		.resetn   (resetn),
		.s_beat   (s_beat),
		.s_valid  (s_valid),
		.s_ready  (s_ready),
		.m_beat   (m_beat),
		.m_valid  (m_valid),
		.m_ready  (m_ready),
		.win_cfg  (win_cfg),
		.img_size (img_size)
	);

	// ------------------------------------------------------------
	// Random bits and the crop model
	// ------------------------------------------------------------

	// Taps 32, 22, 2, 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic three_in_four();
		logic a;
		logic b;
		a = lfsr_bit();
		b = lfsr_bit();
		return a | b;
	endfunction

	function automatic logic [`PIXEL_WIDTH-1:0] pixel_value(input int row, input int col);
		return `PIXEL_WIDTH'(row * 16 + col);
	endfunction

	function automatic window_pkg::win_cfg_t make_cfg(input int l, input int t,
		input int w, input int h);
		window_pkg::win_cfg_t cfg;
		cfg.left   = `IMG_WBITS'(l);
		cfg.top    = `IMG_HBITS'(t);
		cfg.width  = `IMG_WBITS'(w);
		cfg.height = `IMG_HBITS'(h);
		return cfg;
	endfunction

	// Window cut down to the image; empty means zero size.
	function automatic window_pkg::win_cfg_t clamp_window(input window_pkg::win_cfg_t req);
		int l;
		int t;
		int w;
		int h;
		int iw;
		int ih;
		l  = int'(req.left);
		t  = int'(req.top);
		w  = int'(req.width);
		h  = int'(req.height);
		iw = int'(img_size.width);
		ih = int'(img_size.height);
		if (l >= iw || t >= ih || w == 0 || h == 0)
			return make_cfg(0, 0, 0, 0);
		return make_cfg(l, t, (w < iw - l) ? w : iw - l, (h < ih - t) ? h : ih - t);
	endfunction

	function automatic logic inside_window(input window_pkg::win_cfg_t eff,
		input int row, input int col);
		return row >= int'(eff.top) && row < int'(eff.top) + int'(eff.height) &&
			col >= int'(eff.left) && col < int'(eff.left) + int'(eff.width);
	endfunction

	task automatic expect_frame(input window_pkg::win_cfg_t eff);
		video_stream_pkg::axis_beat_t beat;
		int l;
		int t;
		l = int'(eff.left);
		t = int'(eff.top);
		for (int r = t; r < t + int'(eff.height); r++) begin
			for (int c = l; c < l + int'(eff.width); c++) begin
				beat.data = pixel_value(r, c);
				beat.user = (r == t) && (c == l);
				beat.last = (c == l + int'(eff.width) - 1);
				exp_mem[exp_wr] = beat;
				exp_wr++;
			end
		end
		if (eff.width != '0 && eff.height != '0) begin
			exp_counts[exp_frames] = int'(eff.width) * int'(eff.height);
			exp_frames++;
		end
	endtask

	// ------------------------------------------------------------
	// Raster source
	// ------------------------------------------------------------

	// Holds the beat until the handshake; entered just after a rising edge.
	task automatic send_pixel(input int row, input int col, input logic kept);
		logic accepted;
		s_beat.data = pixel_value(row, col);
		s_beat.user = (row == 0) && (col == 0);
		s_beat.last = (col == COLS - 1);
		accepted = 1'b0;
		while (!accepted) begin
			if (!s_valid)
				s_valid = three_in_four();
			m_ready = three_in_four();
			@(negedge clk);
			accepted = s_valid && s_ready;
			if (accepted && kept)
				kept_seen = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		s_valid = 1'b0;
	endtask

	task automatic send_frame(input window_pkg::win_cfg_t first_cfg,
		input int change_row, input window_pkg::win_cfg_t later_cfg);
		window_pkg::win_cfg_t eff;
		win_cfg = first_cfg;
		eff     = clamp_window(first_cfg);
		expect_frame(eff);
		for (int r = 0; r < ROWS; r++) begin
			if (r == change_row)
				win_cfg = later_cfg;   // Must wait for the next frame.
			for (int c = 0; c < COLS; c++)
				send_pixel(r, c, inside_window(eff, r, c));
		end
	endtask

	// ------------------------------------------------------------
	// Output tracking
	// ------------------------------------------------------------

	assign exp_head  = exp_mem[exp_rd];
	assign exp_avail = exp_rd < exp_wr;

	always @(posedge clk) begin
		if (resetn && m_valid && m_ready) begin
			exp_rd <= exp_rd + 1;
			if (m_beat.user) begin
				obs_counts[obs_frames] <= 1;
				obs_frames <= obs_frames + 1;
			end else if (obs_frames > 0) begin
				obs_counts[obs_frames-1] <= obs_counts[obs_frames-1] + 1;
			end
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------

	a_beat_expected: assert property (
		@(posedge clk) disable iff (!resetn)
		m_valid && m_ready |-> exp_avail
	) else begin
		count_errors++;
		$display("Output beat at %0t arrived when the model expected none", $time);
	end

	a_data: assert property (
		@(posedge clk) disable iff (!resetn)
		m_valid && m_ready && exp_avail |-> m_beat.data == exp_head.data
	) else begin
		data_errors++;
		$display("FAIL time=%0t m_beat.data expected=%02h actual=%02h", $time,
			$sampled(exp_head.data), $sampled(m_beat.data));
	end

	a_user: assert property (
		@(posedge clk) disable iff (!resetn)
		m_valid && m_ready && exp_avail |-> m_beat.user == exp_head.user
	) else begin
		user_errors++;
		$display("FAIL time=%0t m_beat.user expected=%0b actual=%0b", $time,
			$sampled(exp_head.user), $sampled(m_beat.user));
	end

	a_last: assert property (
		@(posedge clk) disable iff (!resetn)
		m_valid && m_ready && exp_avail |-> m_beat.last == exp_head.last
	) else begin
		last_errors++;
		$display("FAIL time=%0t m_beat.last expected=%0b actual=%0b", $time,
			$sampled(exp_head.last), $sampled(m_beat.last));
	end

	a_stall_hold: assert property (
		@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat)
	) else begin
		protocol_errors++;
		$display("Output beat changed or was withdrawn while stalled at %0t", $time);
	end

	a_idle_after_reset: assert property (
		@(posedge clk) disable iff (!resetn)
		!kept_seen |-> !m_valid && s_ready
	) else begin
		protocol_errors++;
		$display("Output went valid or input not ready before any kept beat at %0t", $time);
	end

	task automatic print_error_counts();
		$display("Errors: data=%0d user=%0d last=%0d count=%0d protocol=%0d",
			data_errors, user_errors, last_errors, count_errors, protocol_errors);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d of %0d beats out", cycles,
				exp_rd, exp_wr);
			print_error_counts();
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------

	initial begin
		int total;
		resetn   = 1'b0;
		s_beat   = '0;
		s_valid  = 1'b0;
		m_ready  = 1'b0;
		win_cfg  = '0;
		img_size.width  = `IMG_WBITS'(COLS);
		img_size.height = `IMG_HBITS'(ROWS);
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		resetn = 1'b1;

		send_frame(make_cfg(2, 3, 4, 5), ROWS, make_cfg(0, 0, 0, 0));     // Interior.
		send_frame(make_cfg(7, 6, 6, 8), ROWS, make_cfg(0, 0, 0, 0));     // Overhang.
		send_frame(make_cfg(0, 0, 10, 10), ROWS, make_cfg(0, 0, 0, 0));   // Full image.
		send_frame(make_cfg(10, 2, 3, 3), ROWS, make_cfg(0, 0, 0, 0));    // Empty.
		// New window arrives while row 2 of the old one is still to come.
		send_frame(make_cfg(1, 1, 3, 2), 2, make_cfg(5, 2, 5, 6));
		send_frame(make_cfg(5, 2, 5, 6), ROWS, make_cfg(0, 0, 0, 0));

		while (exp_rd < exp_wr) begin
			m_ready = three_in_four();
			@(posedge clk);
			#DRIVE_DELAY;
		end
		m_ready = 1'b1;
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;

		// Beats per non-empty frame.
		assert (obs_frames == exp_frames) else begin
			count_errors++;
			$display("FAIL time=%0t frames expected=%0d actual=%0d", $time,
				exp_frames, obs_frames);
		end
		for (int i = 0; i < exp_frames; i++) begin
			assert (obs_counts[i] == exp_counts[i]) else begin
				count_errors++;
				$display("FAIL time=%0t frame_beats[%0d] expected=%0d actual=%0d",
					$time, i, exp_counts[i], obs_counts[i]);
			end
		end

		total = data_errors + user_errors + last_errors + count_errors + protocol_errors;
		print_error_counts();
		if (total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== rtl/video_window_top.sv ====
`timescale 1ns/1ns

module video_window_top (
	input  logic                         clk,
	input  logic                         resetn,
	input  video_stream_pkg::axis_beat_t s_beat,
	input  logic                         s_valid,
	output logic                         s_ready,
	output video_stream_pkg::axis_beat_t m_beat,
	output logic                         m_valid,
	input  logic                         m_ready,
	input  window_pkg::win_cfg_t         win_cfg,
	input  window_pkg::img_size_t        img_size
);

	logic                   s_fire;
	window_pkg::pixel_pos_t pos;
	window_pkg::win_cfg_t   eff_cfg;

	assign s_fire = s_valid && s_ready;   // Input handshake.

	// ------------------------------------------------------------
	// Position and window of the current beat
	// ------------------------------------------------------------

	video_pos_counter video_pos_counter_inst (
		.clk    (clk),
		.resetn (resetn),
		.s_fire (s_fire),
		.s_user (s_beat.user),
		.s_last (s_beat.last),
		.pos    (pos)
	);

	window_cfg_latch window_cfg_latch_inst (
		.clk      (clk),
		.resetn   (resetn),
		.s_fire   (s_fire),
		.sof      (pos.sof),
		.win_cfg  (win_cfg),
		.img_size (img_size),
		.eff_cfg  (eff_cfg)
	);

	// ------------------------------------------------------------
	// Crop
	// ------------------------------------------------------------

	axis_window axis_window_inst (
		.clk     (clk),
		.resetn  (resetn),
		.s_beat  (s_beat),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.pos     (pos),
		.eff_cfg (eff_cfg),
		.m_beat  (m_beat),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

endmodule

// ==== rtl/axis_window.sv ====
`timescale 1ns/1ns
`include "video_consts.svh"

module axis_window (
	input  logic                         clk,
	input  logic                         resetn,
	input  video_stream_pkg::axis_beat_t s_beat,
	input  logic                         s_valid,
	output logic                         s_ready,
	input  window_pkg::pixel_pos_t       pos,
	input  window_pkg::win_cfg_t         eff_cfg,
	output video_stream_pkg::axis_beat_t m_beat,
	output logic                         m_valid,
	input  logic                         m_ready
);

	logic [`IMG_WBITS:0]          col_end;    // left + width
	logic [`IMG_HBITS:0]          row_end;    // top + height
	logic [`IMG_WBITS:0]          col_next;
	logic                         in_cols;
	logic                         in_rows;
	logic                         keep;
	logic                         first_pix;
	logic                         row_end_pix;
	logic                         load;
	video_stream_pkg::axis_beat_t out_beat;
	video_stream_pkg::axis_beat_t beat_q;
	logic                         valid_q;

	// ------------------------------------------------------------
	// Window bounds
	// ------------------------------------------------------------

	// One extra bit so the sums cannot wrap.
	assign col_end  = {1'b0, eff_cfg.left} + eff_cfg.width;
	assign row_end  = {1'b0, eff_cfg.top} + eff_cfg.height;
	assign col_next = {1'b0, pos.col} + 1'b1;

	// ------------------------------------------------------------
	// Keep or drop
	// ------------------------------------------------------------

	assign in_cols = (pos.col >= eff_cfg.left) && ({1'b0, pos.col} < col_end);
	assign in_rows = (pos.row >= eff_cfg.top) && ({1'b0, pos.row} < row_end);
	assign keep    = in_cols && in_rows;

	// Markers of the cropped frame. Only looked at when keep is set.
	assign first_pix   = (pos.row == eff_cfg.top) && (pos.col == eff_cfg.left);
	assign row_end_pix = (col_next == col_end);

	always_comb begin
		out_beat.data = s_beat.data;
		out_beat.user = first_pix;
		out_beat.last = row_end_pix;
	end

	// ------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------

	// Free when empty or when its beat leaves in this cycle.
	assign s_ready = !valid_q || m_ready;
	assign load    = s_valid && s_ready && keep;

	always_ff @(posedge clk) begin
		if (!resetn)
			valid_q <= 1'b0;
		else if (s_ready)
			valid_q <= s_valid && keep;   // Dropped beats leave it empty.
	end

	always_ff @(posedge clk) begin
		if (load)
			beat_q <= out_beat;
	end

	assign m_beat  = beat_q;
	assign m_valid = valid_q;

	// A stalled beat must wait unchanged.
	a_hold_under_stall: assert property (
		@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat)
	) else $error("axis_window: output beat changed while stalled");

endmodule

// ==== rtl/window_cfg_latch.sv ====
`timescale 1ns/1ns
`include "video_consts.svh"

module window_cfg_latch (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  s_fire,
	input  logic                  sof,
	input  window_pkg::win_cfg_t  win_cfg,
	input  window_pkg::img_size_t img_size,
	output window_pkg::win_cfg_t  eff_cfg
);

	window_pkg::win_cfg_t  clamped;
	window_pkg::win_cfg_t  cfg_q;
	logic [`IMG_WBITS-1:0] room_w;
	logic [`IMG_HBITS-1:0] room_h;
	logic                  empty;
	logic [`IMG_WBITS:0]   right_edge;
	logic [`IMG_HBITS:0]   bottom_edge;

	// ------------------------------------------------------------
	// Clamp the request to the image
	// ------------------------------------------------------------

	assign empty = (win_cfg.left >= img_size.width) ||
		(win_cfg.top >= img_size.height) ||
		(win_cfg.width == '0) ||
		(win_cfg.height == '0);

	// Only meaningful when the window is not empty.
	assign room_w = img_size.width - win_cfg.left;
	assign room_h = img_size.height - win_cfg.top;

	always_comb begin
		if (empty) begin
			clamped = '0;   // Zero size keeps nothing.
		end else begin
			clamped.left   = win_cfg.left;
			clamped.top    = win_cfg.top;
			clamped.width  = (win_cfg.width < room_w) ? win_cfg.width : room_w;
			clamped.height = (win_cfg.height < room_h) ? win_cfg.height : room_h;
		end
	end

	// ------------------------------------------------------------
	// Hold for the frame
	// ------------------------------------------------------------

	// The start-of-frame beat already needs the new window.
	assign eff_cfg = sof ? clamped : cfg_q;

	always_ff @(posedge clk) begin
		if (!resetn)
			cfg_q <= '0;
		else if (s_fire && sof)
			cfg_q <= clamped;
	end

	assign right_edge  = {1'b0, cfg_q.left} + cfg_q.width;
	assign bottom_edge = {1'b0, cfg_q.top} + cfg_q.height;

	a_cfg_inside_image: assert property (
		@(posedge clk) disable iff (!resetn)
		s_fire && sof |=> (right_edge <= $past(img_size.width)) &&
			(bottom_edge <= $past(img_size.height))
	) else $error("window_cfg_latch: stored window extends past the image");

endmodule

// ==== rtl/video_pos_counter.sv ====
`timescale 1ns/1ns
`include "video_consts.svh"

module video_pos_counter (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   s_fire,
	input  logic                   s_user,
	input  logic                   s_last,
	output window_pkg::pixel_pos_t pos
);

	logic [`IMG_HBITS-1:0] row_q;
	logic [`IMG_WBITS-1:0] col_q;
	logic [`IMG_HBITS-1:0] row_cur;
	logic [`IMG_WBITS-1:0] col_cur;

	// ------------------------------------------------------------
	// Position of the beat now on the input
	// ------------------------------------------------------------

	// A tuser beat is the origin, whatever the counters hold.
	assign row_cur = s_user ? '0 : row_q;
	assign col_cur = s_user ? '0 : col_q;

	assign pos.row = row_cur;
	assign pos.col = col_cur;
	assign pos.sof = s_user;

	// ------------------------------------------------------------
	// Advance on every accepted beat
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_q <= '0;
			col_q <= '0;
		end else if (s_fire) begin
			if (s_last) begin
				row_q <= row_cur + 1'b1;   // Next row.
				col_q <= '0;
			end else begin
				row_q <= row_cur;
				col_q <= col_cur + 1'b1;
			end
		end
	end

	// Rows longer than the counter would wrap and alias the window.
	a_col_in_range: assert property (
		@(posedge clk) disable iff (!resetn)
		s_fire && !s_last |=> col_q != {`IMG_WBITS{1'b1}}
	) else $error("video_pos_counter: column counter reached its limit");

endmodule

// ==== rtl/window_pkg.sv ====
`include "video_consts.svh"

package window_pkg;

	// ------------------------------------------------------------
	// Window and image geometry
	// ------------------------------------------------------------

	typedef struct packed {
		logic [`IMG_WBITS-1:0] left;
		logic [`IMG_HBITS-1:0] top;
		logic [`IMG_WBITS-1:0] width;
		logic [`IMG_HBITS-1:0] height;
	} win_cfg_t;

	typedef struct packed {
		logic [`IMG_WBITS-1:0] width;
		logic [`IMG_HBITS-1:0] height;
	} img_size_t;

	// Position of the beat on the input side.
	typedef struct packed {
		logic [`IMG_HBITS-1:0] row;
		logic [`IMG_WBITS-1:0] col;
		logic                  sof;   // Beat carries tuser.
	} pixel_pos_t;

endpackage

// ==== rtl/video_stream_pkg.sv ====
`include "video_consts.svh"

package video_stream_pkg;

	// ------------------------------------------------------------
	// One beat of the pixel stream
	// ------------------------------------------------------------

	// Valid and ready travel beside the beat, not inside it.
	typedef struct packed {
		logic [`PIXEL_WIDTH-1:0] data;
		logic                    user;   // First pixel of a frame.
		logic                    last;   // Last pixel of a row.
	} axis_beat_t;

endpackage

// ==== rtl/video_consts.svh ====
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ------------------------------------------------------------
// Pixel format
// ------------------------------------------------------------

`define PIXEL_WIDTH 8   // Bits per pixel, one pixel per beat.

// ------------------------------------------------------------
// Image geometry
// ------------------------------------------------------------

// Counter widths for column and row.
`define IMG_WBITS 12
`define IMG_HBITS 12

`endif
